//--- all.f
src/fft_pkg.sv
src/fft_regs.sv
src/fft_sample_ram.sv
src/fft_twiddle_rom.sv
src/fft_butterfly.sv
src/fft_sequencer.sv
src/fft_core_top.sv
test/tb_clock.sv
test/tb_fft.sv

//--- test/tb_fft.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fft
	import fft_pkg::*;
();

	localparam int      HS_LIMIT    = 64;
	localparam int      RUN_LIMIT   = 2000;
	localparam int      RESET_LIMIT = 32;
	localparam real     PI          = 3.14159265358979;
	localparam real     TW_SCALE    = 2.0 ** TWIDDLE_FRAC;
	localparam sample_t IMPULSE_AMP = 16'sd3200;
	// the impulse spreads evenly over all 32 bins
	localparam sample_t IMPULSE_OUT = 16'sd100;
	localparam logic [AXI_ADDR_W-1:0] UNMAPPED = 8'h40;

	logic                  clk;
	logic                  arst_n;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [31:0]           wdata;
	logic [3:0]            wstrb;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [31:0]           rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic                  done;

	integer seed;
	logic   bp_en;
	cplx_t  in_frame [FFT_POINTS];
	cplx_t  exp_frame [FFT_POINTS];
	cplx_t  exp_q [$];
	cplx_t  got_q [$];
	event   got_ev;

	tb_clock i_tb_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	fft_core_top i_fft_core_top (
		.clk     (clk),
		.arst_n  (arst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.done    (done)
	);

	// ########################################################################
	// failure reporting and compare tasks
	// ########################################################################

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_cplx(input string name, input cplx_t exp, input cplx_t act);
		if (act !== exp)
			abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
			abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			abort_run($sformatf("** Error at %0t: %s expected %h, got %h", $time, name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("** Error at %0t: %s expected %b, got %b", $time, name, exp, act));
	endtask

	// ########################################################################
	// reference model
	// ########################################################################

	function automatic int reverse_bits(input int idx);
		int r;
		r = 0;
		for (int i = 0; i < ADDR_W; i++)
			r = r | (((idx >> i) & 1) << (ADDR_W - 1 - i));
		return r;
	endfunction

	function automatic int round_nearest(input real x);
		if (x >= 0.0)
			return $rtoi(x + 0.5);
		else
			return -$rtoi(0.5 - x);
	endfunction

	// in-place radix-2 DIT over in_frame, natural order result in exp_frame
	function automatic void fft_ref();
		cplx_t m [FFT_POINTS];
		cplx_t prod;
		int    half;
		int    top;
		int    bot;
		int    k;
		int    tw_re;
		int    tw_im;
		int    p_re;
		int    p_im;
		int    acc;
		real   ang;
		for (int n = 0; n < FFT_POINTS; n++)
			m[reverse_bits(n)] = in_frame[n];
		for (int s = 0; s < FFT_STAGES; s++)
		begin
			half = 1 << s;
			for (int g = 0; g < FFT_POINTS; g += 2 * half)
			begin
				for (int j = 0; j < half; j++)
				begin
					top   = g + j;
					bot   = top + half;
					k     = j * FFT_POINTS / (2 * half);
					ang   = 2.0 * PI * k / FFT_POINTS;
					tw_re = round_nearest(TW_SCALE * $cos(ang));
					tw_im = round_nearest(-TW_SCALE * $sin(ang));
					p_re  = int'(m[bot].re) * tw_re - int'(m[bot].im) * tw_im;
					p_im  = int'(m[bot].re) * tw_im + int'(m[bot].im) * tw_re;
					p_re  = p_re >>> TWIDDLE_FRAC;
					p_im  = p_im >>> TWIDDLE_FRAC;
					prod.re = p_re[SAMPLE_W-1:0];
					prod.im = p_im[SAMPLE_W-1:0];
					// bottom first, it still needs the old top
					acc = (int'(m[top].re) - int'(prod.re)) >>> 1;
					m[bot].re = acc[SAMPLE_W-1:0];
					acc = (int'(m[top].im) - int'(prod.im)) >>> 1;
					m[bot].im = acc[SAMPLE_W-1:0];
					acc = (int'(m[top].re) + int'(prod.re)) >>> 1;
					m[top].re = acc[SAMPLE_W-1:0];
					acc = (int'(m[top].im) + int'(prod.im)) >>> 1;
					m[top].im = acc[SAMPLE_W-1:0];
				end
			end
		end
		for (int n = 0; n < FFT_POINTS; n++)
			exp_frame[n] = m[n];
	endfunction

	function automatic logic [AXI_ADDR_W-1:0] win_addr(input int n);
		return WIN_BASE + AXI_ADDR_W'(4 * n);
	endfunction

	// ########################################################################
	// host bus tasks
	// ########################################################################

	task automatic write_word(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int hold;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		forever
		begin
			@(posedge clk);
			if (awready && wready)
				break;
			n++;
			if (n > HS_LIMIT)
				abort_run("timeout waiting for awready and wready");
		end
		#2;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		hold    = bp_en ? ($random(seed) & 15) : 0;
		bready  = (hold == 0);
		n = 0;
		forever
		begin
			@(posedge clk);
			if (bvalid && bready)
				break;
			n++;
			if (n > HS_LIMIT)
				abort_run("timeout waiting for bvalid");
			#2;
			if (hold > 0)
				hold--;
			bready = (hold == 0);
		end
		resp = bresp;
		#2;
		bready = 1'b0;
		if (bvalid)
			abort_run("write response stayed valid after its handshake");
	endtask

	task automatic read_word(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		int hold;
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		forever
		begin
			@(posedge clk);
			if (arready)
				break;
			n++;
			if (n > HS_LIMIT)
				abort_run("timeout waiting for arready");
		end
		#2;
		arvalid = 1'b0;
		hold    = bp_en ? ($random(seed) & 15) : 0;
		rready  = (hold == 0);
		n = 0;
		forever
		begin
			@(posedge clk);
			if (rvalid && rready)
				break;
			n++;
			if (n > HS_LIMIT)
				abort_run("timeout waiting for rvalid");
			#2;
			if (hold > 0)
				hold--;
			rready = (hold == 0);
		end
		data = rdata;
		resp = rresp;
		#2;
		rready = 1'b0;
		if (rvalid)
			abort_run("read data stayed valid after its handshake");
	endtask

	task automatic write_and_check(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
			input logic [1:0] exp_resp);
		logic [1:0] resp;
		write_word(addr, data, resp);
		check_resp("bresp", exp_resp, resp);
	endtask

	task automatic read_and_check(input logic [AXI_ADDR_W-1:0] addr, input logic [1:0] exp_resp,
			output logic [31:0] data);
		logic [1:0] resp;
		read_word(addr, data, resp);
		check_resp("rresp", exp_resp, resp);
	endtask

	task automatic read_status(input logic [31:0] exp);
		logic [31:0] data;
		read_and_check(REG_STATUS, RESP_OKAY, data);
		check_word("STATUS", exp, data);
	endtask

	// the compare process pairs each expected word with the word read back
	task automatic read_window(input int n, input cplx_t exp);
		logic [31:0] data;
		exp_q.push_back(exp);
		read_and_check(win_addr(n), RESP_OKAY, data);
		got_q.push_back(data);
		-> got_ev;
	endtask

	task automatic load_frame();
		for (int n = 0; n < FFT_POINTS; n++)
			write_and_check(win_addr(n), in_frame[n], RESP_OKAY);
	endtask

	task automatic start_run();
		write_and_check(REG_CTRL, 32'h1, RESP_OKAY);
		check_flag("done", 1'b0, done);
		read_status(32'h1);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		forever
		begin
			@(posedge clk);
			if (done)
				break;
			n++;
			if (n > RUN_LIMIT)
				abort_run("timeout waiting for done at the end of a run");
		end
		#2;
		read_status(32'h2);
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		forever
		begin
			@(posedge clk);
			if (arst_n)
				break;
			n++;
			if (n > RESET_LIMIT)
				abort_run("reset was never released");
		end
		#2;
	endtask

	// every access that needs an idle engine is refused during the run
	task automatic probe_busy_errors();
		logic [31:0] data;
		write_and_check(REG_CTRL, 32'h1, RESP_SLVERR);
		write_and_check(win_addr(3), 32'hdead_beef, RESP_SLVERR);
		read_and_check(win_addr(3), RESP_SLVERR, data);
		write_and_check(UNMAPPED, 32'h0, RESP_SLVERR);
		read_and_check(UNMAPPED, RESP_SLVERR, data);
		read_status(32'h1);
	endtask

	// ########################################################################
	// compare process
	// ########################################################################

	initial
	begin
		cplx_t exp_v;
		cplx_t got_v;
		forever
		begin
			@(got_ev);
			while (got_q.size() > 0)
			begin
				if (exp_q.size() == 0)
					abort_run("a window word was read back with no expected value");
				exp_v = exp_q.pop_front();
				got_v = got_q.pop_front();
				check_cplx("rdata", exp_v, got_v);
			end
		end
	end

	// ########################################################################
	// test sequence
	// ########################################################################

	initial
	begin
		logic [31:0] data;
		cplx_t       exp_word;
		$timeformat(-9, 1, " ns", 0);
		seed    = 32'h9c10_18be;
		bp_en   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = 4'hf;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		wait_reset();

		check_flag("done", 1'b0, done);
		check_flag("awready", 1'b0, awready);
		check_flag("wready", 1'b0, wready);
		check_flag("arready", 1'b0, arready);
		check_flag("bvalid", 1'b0, bvalid);
		check_flag("rvalid", 1'b0, rvalid);
		read_status(32'h0);

		// window loopback, a word written at n lands at the reversed index
		for (int n = 0; n < FFT_POINTS; n++)
			in_frame[n] = 32'h1000_2000 + n * 32'h0101_0001;
		load_frame();
		for (int n = 0; n < FFT_POINTS; n++)
			read_window(n, in_frame[reverse_bits(n)]);

		write_and_check(UNMAPPED, 32'h0, RESP_SLVERR);
		read_and_check(UNMAPPED, RESP_SLVERR, data);
		write_and_check(REG_STATUS, 32'h0, RESP_SLVERR);

		for (int n = 0; n < FFT_POINTS; n++)
			in_frame[n] = '0;
		in_frame[0].re = IMPULSE_AMP;
		load_frame();
		start_run();
		wait_done();
		exp_word.re = IMPULSE_OUT;
		exp_word.im = '0;
		for (int n = 0; n < FFT_POINTS; n++)
			read_window(n, exp_word);

		// the last frame runs with random holds on bready and rready
		for (int f = 0; f < 3; f++)
		begin
			bp_en = (f == 2);
			for (int n = 0; n < FFT_POINTS; n++)
				in_frame[n] = $random(seed);
			fft_ref();
			load_frame();
			start_run();
			if (f == 1)
				probe_busy_errors();
			wait_done();
			for (int n = 0; n < FFT_POINTS; n++)
				read_window(n, exp_frame[n]);
		end

		@(posedge clk);
		if (exp_q.size() != 0 || got_q.size() != 0)
			abort_run("some read-back words were never compared");
		else
		begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 8;

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	// reset lets go between edges, just after the last reset cycle
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- src/fft_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module fft_core_top
	import fft_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [AXI_ADDR_W-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [AXI_ADDR_W-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	output logic                  done
);

	logic              busy;
	logic              start;
	logic              host_we;
	logic              host_re;
	addr_t             host_addr;
	cplx_t             host_wdata;
	cplx_t             host_rdata;
	addr_t             addr_a;
	addr_t             addr_b;
	cplx_t             wdata_a;
	cplx_t             wdata_b;
	logic              we_a;
	logic              we_b;
	cplx_t             rdata_a;
	cplx_t             rdata_b;
	logic [ADDR_W-2:0] tw_index;
	cplx_t             twiddle;
	logic              in_valid;
	logic              out_valid;
	cplx_t             out_top;
	cplx_t             out_bot;

	fft_regs i_fft_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.awaddr     (awaddr),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wvalid     (wvalid),
		.wready     (wready),
		.bresp      (bresp),
		.bvalid     (bvalid),
		.bready     (bready),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.busy       (busy),
		.host_rdata (host_rdata),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_we    (host_we),
		.host_re    (host_re),
		.start      (start),
		.done       (done)
	);

	fft_sequencer i_fft_sequencer (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.busy       (busy),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_we    (host_we),
		.host_re    (host_re),
		.host_rdata (host_rdata),
		.addr_a     (addr_a),
		.wdata_a    (wdata_a),
		.we_a       (we_a),
		.addr_b     (addr_b),
		.wdata_b    (wdata_b),
		.we_b       (we_b),
		.rdata_a    (rdata_a),
		.tw_index   (tw_index),
		.in_valid   (in_valid),
		.out_valid  (out_valid),
		.out_top    (out_top),
		.out_bot    (out_bot)
	);

	fft_sample_ram i_fft_sample_ram (
		.clk     (clk),
		.addr_a  (addr_a),
		.wdata_a (wdata_a),
		.we_a    (we_a),
		.rdata_a (rdata_a),
		.addr_b  (addr_b),
		.wdata_b (wdata_b),
		.we_b    (we_b),
		.rdata_b (rdata_b)
	);

	fft_twiddle_rom i_fft_twiddle_rom (
		.clk      (clk),
		.tw_index (tw_index),
		.twiddle  (twiddle)
	);

	// memory words feed the butterfly straight from the read ports
	fft_butterfly i_fft_butterfly (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.top       (rdata_a),
		.bot       (rdata_b),
		.twiddle   (twiddle),
		.out_valid (out_valid),
		.out_top   (out_top),
		.out_bot   (out_bot)
	);

endmodule

`default_nettype wire

//--- src/fft_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module fft_sequencer
	import fft_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	output logic              busy,
	input  addr_t             host_addr,
	input  cplx_t             host_wdata,
	input  logic              host_we,
	input  logic              host_re,
	output cplx_t             host_rdata,
	output addr_t             addr_a,
	output cplx_t             wdata_a,
	output logic              we_a,
	output addr_t             addr_b,
	output cplx_t             wdata_b,
	output logic              we_b,
	input  cplx_t             rdata_a,
	output logic [ADDR_W-2:0] tw_index,
	output logic              in_valid,
	input  logic              out_valid,
	input  cplx_t             out_top,
	input  cplx_t             out_bot
);

	// one cycle of memory read ahead of the butterfly pipeline
	localparam int DLY = BFLY_LATENCY + 1;

	stage_t            stage_q;
	logic [ADDR_W-1:0] pair_q;
	logic [ADDR_W-1:0] half;
	logic [ADDR_W-1:0] mask;
	logic [ADDR_W-1:0] pos;
	logic [7:0]        tw_wide;
	addr_t             top_addr;
	addr_t             bot_addr;
	logic              issue;
	logic              drained;
	logic [DLY-1:0]    iss_pipe;
	addr_t             top_dly [DLY];
	addr_t             bot_dly [DLY];

	// the top bit of pair_q marks that all 16 pairs of the stage have issued
	assign half     = ADDR_W'(1) << stage_q;
	assign mask     = half - 1'b1;
	assign pos      = {1'b0, pair_q[ADDR_W-2:0]} & mask;
	assign top_addr = (({1'b0, pair_q[ADDR_W-2:0]} & ~mask) << 1) | pos;
	assign bot_addr = top_addr | half;
	assign tw_wide  = ({3'd0, pos} << 4) >> stage_q;
	assign tw_index = tw_wide[ADDR_W-2:0];

	// a result writing back holds both ports, so no read issues in that cycle
	assign issue   = busy && !pair_q[ADDR_W-1] && !out_valid;
	assign drained = pair_q[ADDR_W-1] && !(|iss_pipe);

	assign in_valid   = iss_pipe[0];
	assign host_rdata = rdata_a;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy     <= 1'b0;
			stage_q  <= '0;
			pair_q   <= '0;
			iss_pipe <= '0;
		end
		else
		begin
			iss_pipe <= {iss_pipe[DLY-2:0], issue};
			if (!busy)
			begin
				if (start)
				begin
					busy    <= 1'b1;
					stage_q <= '0;
					pair_q  <= '0;
				end
			end
			else if (issue)
				pair_q <= pair_q + 1'b1;
			else if (drained)
			begin
				pair_q <= '0;
				if (stage_q == stage_t'(FFT_STAGES - 1))
					busy <= 1'b0;
				else
					stage_q <= stage_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		top_dly[0] <= top_addr;
		bot_dly[0] <= bot_addr;
		for (int i = 1; i < DLY; i++)
		begin
			top_dly[i] <= top_dly[i-1];
			bot_dly[i] <= bot_dly[i-1];
		end
	end

	// results go back in place, top on port a and bottom on port b
	always_comb
	begin
		addr_a  = top_addr;
		addr_b  = bot_addr;
		wdata_a = out_top;
		wdata_b = out_bot;
		we_a    = 1'b0;
		we_b    = 1'b0;
		if (busy)
		begin
			if (out_valid)
			begin
				addr_a = top_dly[DLY-1];
				addr_b = bot_dly[DLY-1];
				we_a   = 1'b1;
				we_b   = 1'b1;
			end
		end
		else if (host_we || host_re)
		begin
			addr_a  = host_addr;
			wdata_a = host_wdata;
			we_a    = host_we;
		end
	end

	a_no_host_write_busy: assert property (@(posedge clk) disable iff (!arst_n)
		busy |-> !host_we);
	a_no_port_collision: assert property (@(posedge clk) disable iff (!arst_n)
		we_a && we_b |-> addr_a != addr_b);

endmodule

`default_nettype wire

//--- src/fft_butterfly.sv
`timescale 1ns/100ps
`default_nettype none

module fft_butterfly
	import fft_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  in_valid,
	input  cplx_t top,
	input  cplx_t bot,
	input  cplx_t twiddle,
	output logic  out_valid,
	output cplx_t out_top,
	output cplx_t out_bot
);

	// full width products plus one bit for the sum of two of them
	logic signed [2*SAMPLE_W:0] mul_re;
	logic signed [2*SAMPLE_W:0] mul_im;
	logic signed [SAMPLE_W:0]   sum_re;
	logic signed [SAMPLE_W:0]   sum_im;
	logic signed [SAMPLE_W:0]   dif_re;
	logic signed [SAMPLE_W:0]   dif_im;
	cplx_t                      top_q;
	cplx_t                      prod_q;
	logic                       mid_valid;

	assign mul_re = bot.re * twiddle.re - bot.im * twiddle.im;
	assign mul_im = bot.re * twiddle.im + bot.im * twiddle.re;

	assign sum_re = top_q.re + prod_q.re;
	assign sum_im = top_q.im + prod_q.im;
	assign dif_re = top_q.re - prod_q.re;
	assign dif_im = top_q.im - prod_q.im;

	always_ff @(posedge clk)
	begin
		// drop the twiddle fraction, then keep the low sample width
		top_q     <= top;
		prod_q.re <= mul_re[TWIDDLE_FRAC +: SAMPLE_W];
		prod_q.im <= mul_im[TWIDDLE_FRAC +: SAMPLE_W];
		// halve every stage so five stages scale the result by 1/32
		out_top.re <= sum_re[SAMPLE_W:1];
		out_top.im <= sum_im[SAMPLE_W:1];
		out_bot.re <= dif_re[SAMPLE_W:1];
		out_bot.im <= dif_im[SAMPLE_W:1];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mid_valid <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			mid_valid <= in_valid;
			out_valid <= mid_valid;
		end
	end

endmodule

`default_nettype wire

//--- src/fft_twiddle_rom.sv
`timescale 1ns/100ps
`default_nettype none

module fft_twiddle_rom
	import fft_pkg::*;
(
	input  logic              clk,
	input  logic [ADDR_W-2:0] tw_index,
	output cplx_t             twiddle
);

	twiddle_t cos_v;
	twiddle_t nsin_v;

	// W32^k = cos(2 pi k/32) - j sin(2 pi k/32), scaled by 2^14 and rounded
	always_comb
	begin
		case (tw_index)
			4'd0:    {nsin_v, cos_v} = {16'sd0, 16'sd16384};
			4'd1:    {nsin_v, cos_v} = {-16'sd3196, 16'sd16069};
			4'd2:    {nsin_v, cos_v} = {-16'sd6270, 16'sd15137};
			4'd3:    {nsin_v, cos_v} = {-16'sd9102, 16'sd13623};
			4'd4:    {nsin_v, cos_v} = {-16'sd11585, 16'sd11585};
			4'd5:    {nsin_v, cos_v} = {-16'sd13623, 16'sd9102};
			4'd6:    {nsin_v, cos_v} = {-16'sd15137, 16'sd6270};
			4'd7:    {nsin_v, cos_v} = {-16'sd16069, 16'sd3196};
			4'd8:    {nsin_v, cos_v} = {-16'sd16384, 16'sd0};
			4'd9:    {nsin_v, cos_v} = {-16'sd16069, -16'sd3196};
			4'd10:   {nsin_v, cos_v} = {-16'sd15137, -16'sd6270};
			4'd11:   {nsin_v, cos_v} = {-16'sd13623, -16'sd9102};
			4'd12:   {nsin_v, cos_v} = {-16'sd11585, -16'sd11585};
			4'd13:   {nsin_v, cos_v} = {-16'sd9102, -16'sd13623};
			4'd14:   {nsin_v, cos_v} = {-16'sd6270, -16'sd15137};
			default: {nsin_v, cos_v} = {-16'sd3196, -16'sd16069};
		endcase
	end

	// registered to line up with the synchronous sample memory
	always_ff @(posedge clk)
	begin
		twiddle.re <= cos_v;
		twiddle.im <= nsin_v;
	end

endmodule

`default_nettype wire

//--- src/fft_sample_ram.sv
`timescale 1ns/100ps
`default_nettype none

module fft_sample_ram
	import fft_pkg::*;
(
	input  logic  clk,
	input  addr_t addr_a,
	input  cplx_t wdata_a,
	input  logic  we_a,
	output cplx_t rdata_a,
	input  addr_t addr_b,
	input  cplx_t wdata_b,
	input  logic  we_b,
	output cplx_t rdata_b
);

	cplx_t mem [FFT_POINTS];

	// both ports are read-first, a write shows up on the next read
	always_ff @(posedge clk)
	begin
		if (we_a)
			mem[addr_a] <= wdata_a;
		if (we_b)
			mem[addr_b] <= wdata_b;
		rdata_a <= mem[addr_a];
		rdata_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

//--- src/fft_regs.sv
`timescale 1ns/100ps
`default_nettype none

module fft_regs
	import fft_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [AXI_ADDR_W-1:0] awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [AXI_ADDR_W-1:0] araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	input  logic                  busy,
	input  cplx_t                 host_rdata,
	output addr_t                 host_addr,
	output cplx_t                 host_wdata,
	output logic                  host_we,
	output logic                  host_re,
	output logic                  start,
	output logic                  done
);

	logic  wr_go;
	logic  wr_hs;
	logic  wr_err;
	logic  aw_win;
	logic  aw_ctrl;
	logic  rd_go;
	logic  rd_hs;
	logic  rd_err;
	logic  ar_win;
	logic  ar_ctrl;
	logic  ar_stat;
	logic  rd_pend;
	logic  rd_win_q;
	logic  rd_stat_q;
	logic  run_q;
	logic  busy_q;
	addr_t aw_idx;
	addr_t ar_idx;

	function automatic addr_t bit_rev(input addr_t idx);
		addr_t r;
		for (int i = 0; i < ADDR_W; i++)
			r[i] = idx[ADDR_W-1-i];
		return r;
	endfunction

	// ########################################################################
	// address decode
	// ########################################################################

	// wstrb is not decoded, every write stores a full word
	assign aw_win  = awaddr >= WIN_BASE;
	assign aw_ctrl = awaddr == REG_CTRL;
	assign ar_win  = araddr >= WIN_BASE;
	assign ar_ctrl = araddr == REG_CTRL;
	assign ar_stat = araddr == REG_STATUS;
	assign aw_idx  = awaddr[ADDR_W+1:2];
	assign ar_idx  = araddr[ADDR_W+1:2];

	// STATUS is read only, so a write there lands in the unmapped case
	assign wr_err = (aw_win && run_q) || (aw_ctrl && wdata[0] && run_q) || !(aw_win || aw_ctrl);
	assign rd_err = (ar_win && run_q) || !(ar_win || ar_ctrl || ar_stat);

	// a write offer wins over a read offer, so the two handshakes never share a cycle
	assign wr_go = awvalid && wvalid && !awready && !bvalid;
	assign rd_go = arvalid && !arready && !rd_pend && !rvalid && !wr_go;
	assign wr_hs = awready && awvalid && wvalid;
	assign rd_hs = arready && arvalid;

	// samples go in bit-reversed so the engine can skip the input permutation
	assign host_addr  = wr_hs ? bit_rev(aw_idx) : ar_idx;
	assign host_wdata = cplx_t'(wdata);
	assign host_we    = wr_hs && aw_win && !run_q;
	assign host_re    = rd_hs && ar_win && !run_q;
	assign start      = wr_hs && aw_ctrl && wdata[0] && !run_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rd_pend <= 1'b0;
			rvalid  <= 1'b0;
			busy_q  <= 1'b0;
			run_q   <= 1'b0;
			done    <= 1'b0;
		end
		else
		begin
			awready <= wr_go;
			wready  <= wr_go;
			arready <= rd_go;
			rd_pend <= rd_hs;
			busy_q  <= busy;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			// memory data is back one cycle after the handshake
			if (rd_pend)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			// status busy and done change on the same edge
			if (start)
			begin
				run_q <= 1'b1;
				done  <= 1'b0;
			end
			else if (busy_q && !busy)
			begin
				run_q <= 1'b0;
				done  <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_hs)
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
		if (rd_hs)
		begin
			rresp     <= rd_err ? RESP_SLVERR : RESP_OKAY;
			rd_win_q  <= ar_win && !run_q;
			rd_stat_q <= ar_stat;
		end
		if (rd_pend)
			rdata <= rd_win_q ? host_rdata : rd_stat_q ? {30'd0, done, run_q} : 32'd0;
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid);
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- src/fft_pkg.sv
`default_nettype none

package fft_pkg;

	// ########################################################################
	// transform geometry
	// ########################################################################

	localparam int FFT_POINTS   = 32;
	localparam int FFT_STAGES   = 5;
	localparam int ADDR_W       = 5;
	localparam int SAMPLE_W     = 16;
	localparam int TWIDDLE_FRAC = 14;

	// one register stage for the product and one for the sum and difference
	localparam int BFLY_LATENCY = 2;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SAMPLE_W-1:0] twiddle_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [2:0] stage_t;

	// real part sits in the low half, so a bus word reads as {im, re}
	typedef struct packed {
		sample_t im;
		sample_t re;
	} cplx_t;

	// ########################################################################
	// host register map
	// ########################################################################

	localparam int AXI_ADDR_W = 8;

	localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 8'h00;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 8'h04;

	// word n of the sample window lives at WIN_BASE + 4n
	localparam logic [AXI_ADDR_W-1:0] WIN_BASE   = 8'h80;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire
